//--- conv_layer_config.svh
`ifndef CONV_LAYER_CONFIG_SVH
`define CONV_LAYER_CONFIG_SVH

// Layer geometry
`define CL_CHANNELS 8
`define CL_TAPS     5
`define CL_FILTERS  4

// Activation, weight and result width
`define CL_DATA_W   8

// Requantization
`define CL_SHIFT    7
`define CL_SAT_MAX  127

`endif

//--- conv_types_pkg.sv
`include "conv_layer_config.svh"

package conv_types_pkg;

    // Product of two data words plus growth over the taps
    localparam int PARTIAL_W = 2 * `CL_DATA_W + $clog2(`CL_TAPS);
    // Growth over the channels
    localparam int ACC_W     = PARTIAL_W + $clog2(`CL_CHANNELS);

    typedef logic signed [`CL_DATA_W-1:0] act_t;
    typedef act_t [`CL_TAPS-1:0] act_window_t;

    typedef struct packed {
        act_window_t [`CL_CHANNELS-1:0] win;
    } act_frame_t;

    typedef logic signed [PARTIAL_W-1:0] partial_t;
    typedef partial_t [`CL_FILTERS-1:0] partial_vec_t;

    typedef logic signed [ACC_W-1:0] acc_t;
    typedef acc_t [`CL_FILTERS-1:0] acc_vec_t;

    typedef logic signed [`CL_DATA_W-1:0] result_t;
    typedef result_t [`CL_FILTERS-1:0] result_vec_t;

endpackage

//--- conv_weights_pkg.sv
`include "conv_layer_config.svh"

package conv_weights_pkg;

    typedef logic signed [`CL_DATA_W-1:0] weight_t;

    // Indexed filter, channel, tap; each row lists tap 4 down to tap 0
    localparam weight_t kernel_table [0:`CL_FILTERS-1][0:`CL_CHANNELS-1][`CL_TAPS-1:0] = '{
        '{
            '{-17,  -9,  -2, -14,  97},
            '{-79,  56, -68, 105,  81},
            '{-63,  73, -30,  12,  25},
            '{ 66,  -9, -65,  41,  -1},
            '{-40,  77,  92,  69,   6},
            '{ 67,  93, -65, -17,  77},
            '{ -1, -67,  89, -72,  47},
            '{ 25, -77,   4,  43,  82}
        },
        '{
            '{-78, -71, -112, -37, -84},
            '{ 17,  -4,   36, -81, -38},
            '{-97,  -2,  -76, -41,  48},
            '{ 48, -53,   16,  22, -60},
            '{-72,  45,   35,  80,  16},
            '{-27, -79,   91,  -9,  50},
            '{-61,  27,  -45,  91, -13},
            '{-52,  26,  -66,  92,  28}
        },
        '{
            '{ -7, -93, -69, -94,  -4},
            '{ 55,  -7, -49,  13, -96},
            '{ 43, -71,  87, -52,  62},
            '{-43, -89,  30,  77, -29},
            '{-82,  86,  83, -35,  62},
            '{-81,  71,  32,  14, -58},
            '{ 50,  43,  60, -85,  -3},
            '{ -7,  72,  45, -30,  54}
        },
        '{
            '{ -4, -30, 111, 100,  26},
            '{-15,  11,  29,   6, -63},
            '{-16,   5,  -9,  80,  31},
            '{ -5,  87, -49,  64, -61},
            '{ 20,  38,  75, -16,  31},
            '{-69, -25, -40, -87,  -8},
            '{-83, -78, -32,  48, -88},
            '{ 66,  -6, -41,  13,  85}
        }
    };

    function automatic weight_t weight_of(
        input int unsigned filt,
        input int unsigned chan,
        input int unsigned tap
    );
        return kernel_table[filt][chan][tap];
    endfunction

endpackage

//--- conv_input_stage.sv
`timescale 1ns/1ps
`include "conv_layer_config.svh"

module conv_input_stage
    import conv_types_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       en,
    input  act_frame_t act_in,
    output act_frame_t frame,
    output logic       frame_valid
);

    // One pulse per accepted frame
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= en;
        end
    end

    // Frame holds between strobes
    always_ff @(posedge clk) begin
        if (en) begin
            frame <= act_in;
        end
    end

    a_act_in_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        en |-> !$isunknown(act_in)
    ) else $error("act_in has unknown bits while en is high");

endmodule

//--- conv_channel_mac.sv
`timescale 1ns/1ps
`include "conv_layer_config.svh"

module conv_channel_mac
    import conv_types_pkg::*;
    import conv_weights_pkg::*;
#(
    parameter int CHANNEL = 0
) (
    input  logic         clk,
    input  logic         rst_n,
    input  act_window_t  window,
    input  logic         in_valid,
    output partial_vec_t partials,
    output logic         mac_valid
);

    partial_vec_t dot;

    // One 5-tap dot product per filter, weights fixed for this channel
    always_comb begin
        for (int f = 0; f < `CL_FILTERS; f++) begin
            dot[f] = '0;
            for (int t = 0; t < `CL_TAPS; t++) begin
                dot[f] = dot[f] + partial_t'(window[t] * weight_of(f, CHANNEL, t));
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mac_valid <= 1'b0;
        end else begin
            mac_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            partials <= dot;
        end
    end

endmodule

//--- conv_filter_sum.sv
`timescale 1ns/1ps
`include "conv_layer_config.svh"

module conv_filter_sum
    import conv_types_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  partial_vec_t partials [`CL_CHANNELS],
    input  logic         in_valid,
    output acc_vec_t     sums,
    output logic         sum_valid
);

    acc_vec_t total;

    // Sign extend each channel partial before the add
    always_comb begin
        for (int f = 0; f < `CL_FILTERS; f++) begin
            total[f] = '0;
            for (int c = 0; c < `CL_CHANNELS; c++) begin
                total[f] = total[f] + acc_t'(partials[c][f]);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            sums <= total;
        end
    end

    a_sums_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        sum_valid |-> !$isunknown(sums)
    ) else $error("sums has unknown bits while sum_valid is high");

endmodule

//--- conv_requant.sv
`timescale 1ns/1ps
`include "conv_layer_config.svh"

module conv_requant
    import conv_types_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  acc_vec_t    sums,
    input  logic        in_valid,
    output result_vec_t out,
    output logic        out_valid
);

    localparam acc_t SAT_HI = acc_t'(`CL_SAT_MAX);
    localparam acc_t SAT_LO = -SAT_HI;

    result_vec_t clipped;

    always_comb begin
        for (int f = 0; f < `CL_FILTERS; f++) begin
            acc_t shifted;
            // Arithmetic shift, rounds toward minus infinity
            shifted = sums[f] >>> `CL_SHIFT;
            if (shifted > SAT_HI) begin
                clipped[f] = result_t'(SAT_HI);
            end else if (shifted < SAT_LO) begin
                clipped[f] = result_t'(SAT_LO);
            end else begin
                clipped[f] = result_t'(shifted);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out       <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin
                out <= clipped;
            end
        end
    end

    // Symmetric range, -128 never leaves the layer
    for (genvar f = 0; f < `CL_FILTERS; f++) begin : g_range_chk
        a_no_min_code: assert property (
            @(posedge clk) disable iff (!rst_n)
            out[f] >= -(`CL_SAT_MAX)
        ) else $error("out[%0d] holds the code -128", f);
    end

endmodule

//--- conv_layer.sv
`timescale 1ns/1ps
`include "conv_layer_config.svh"

module conv_layer
    import conv_types_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        en,
    input  act_frame_t  act_in,
    output result_vec_t out,
    output logic        out_valid
);

    act_frame_t             frame;
    logic                   frame_valid;
    partial_vec_t           ch_partials [`CL_CHANNELS];
    logic [`CL_CHANNELS-1:0] mac_valid;
    acc_vec_t               sums;
    logic                   sum_valid;

    conv_input_stage u_input (
        .clk         (clk),
        .rst_n       (rst_n),
        .en          (en),
        .act_in      (act_in),
        .frame       (frame),
        .frame_valid (frame_valid)
    );

    for (genvar c = 0; c < `CL_CHANNELS; c++) begin : g_mac
        conv_channel_mac #(
            .CHANNEL (c)
        ) u_mac (
            .clk       (clk),
            .rst_n     (rst_n),
            .window    (frame.win[c]),
            .in_valid  (frame_valid),
            .partials  (ch_partials[c]),
            .mac_valid (mac_valid[c])
        );
    end

    // All MAC lanes share timing, lane 0 carries the valid
    conv_filter_sum u_sum (
        .clk       (clk),
        .rst_n     (rst_n),
        .partials  (ch_partials),
        .in_valid  (mac_valid[0]),
        .sums      (sums),
        .sum_valid (sum_valid)
    );

    conv_requant u_requant (
        .clk       (clk),
        .rst_n     (rst_n),
        .sums      (sums),
        .in_valid  (sum_valid),
        .out       (out),
        .out_valid (out_valid)
    );

endmodule

//--- tb_conv_layer.sv
`timescale 1ns/1ps
`include "conv_layer_config.svh"

module tb_conv_layer
    import conv_types_pkg::*;
    import conv_weights_pkg::*;
();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 5;
    localparam int LATENCY      = 4;
    localparam int N_B2B        = 64;
    localparam int N_GAP        = 128;
    localparam int N_SAT        = 32;
    localparam int N_FLIGHT     = 6;
    localparam int N_AFTER      = 32;
    localparam int DRAIN        = 8;
    localparam int TOTAL_CYCLES = 2 * RESET_CYCLES + N_B2B + N_GAP + N_SAT + N_FLIGHT
                                + N_AFTER + 5 * DRAIN;
    localparam int WATCHDOG_NS  = (TOTAL_CYCLES + 100) * CLK_PERIOD;

    logic        clk;
    logic        rst_n;
    logic        en;
    act_frame_t  act_in;
    result_vec_t out;
    logic        out_valid;

    // Expected results and the cycle each one is due
    result_vec_t exp_q [$];
    int          due_q [$];

    int ncyc;
    int n_en;
    int n_out;
    int n_dropped;
    bit reset_seen;

    conv_layer dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (en),
        .act_in    (act_in),
        .out       (out),
        .out_valid (out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("Mismatch %s: expected 0x%0h, actual 0x%0h",
                               name, expected, actual));
        end
    endtask

    // Reference model of one frame through the layer
    function automatic result_vec_t model_layer(input act_frame_t fr);
        result_vec_t res;
        int          sum;
        int          q;
        for (int f = 0; f < `CL_FILTERS; f++) begin
            sum = 0;
            for (int c = 0; c < `CL_CHANNELS; c++) begin
                for (int t = 0; t < `CL_TAPS; t++) begin
                    sum += int'(fr.win[c][t]) * int'(weight_of(f, c, t));
                end
            end
            q = sum >>> `CL_SHIFT;
            if (q > `CL_SAT_MAX) begin
                q = `CL_SAT_MAX;
            end else if (q < -`CL_SAT_MAX) begin
                q = -`CL_SAT_MAX;
            end
            res[f] = q[7:0];
        end
        return res;
    endfunction

    function automatic act_frame_t random_frame();
        act_frame_t fr;
        for (int c = 0; c < `CL_CHANNELS; c++) begin
            for (int t = 0; t < `CL_TAPS; t++) begin
                fr.win[c][t] = act_t'($urandom());
            end
        end
        return fr;
    endfunction

    // Each tap follows the sign of its weight so the chosen filter overflows
    function automatic act_frame_t saturating_frame(input int filt, input bit positive);
        act_frame_t fr;
        bit         w_pos;
        for (int c = 0; c < `CL_CHANNELS; c++) begin
            for (int t = 0; t < `CL_TAPS; t++) begin
                w_pos = (weight_of(filt, c, t) >= 0);
                if (w_pos == positive) begin
                    fr.win[c][t] = act_t'(127);
                end else begin
                    fr.win[c][t] = act_t'(-128);
                end
            end
        end
        return fr;
    endfunction

    task automatic drive_cycle(input logic e, input act_frame_t fr);
        @(posedge clk);
        en     <= e;
        act_in <= fr;
    endtask

    task automatic idle(input int n);
        repeat (n) drive_cycle(1'b0, random_frame());
    endtask

    task automatic check_drained(input string phase);
        if (exp_q.size() != 0) begin
            fail_run($sformatf("%0d frames of the %s phase never produced out_valid",
                               exp_q.size(), phase));
        end
    endtask

    task automatic apply_reset(input int cycles);
        @(posedge clk);
        rst_n <= 1'b0;
        en    <= 1'b0;
        repeat (cycles) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    // Outputs are sampled on the falling edge
    always @(negedge clk) begin
        result_vec_t exp_res;
        int          due;
        ncyc++;
        if (!rst_n) begin
            n_dropped += exp_q.size();
            exp_q.delete();
            due_q.delete();
            reset_seen = 1'b1;
            check_value("out_valid", 32'h0, {31'h0, out_valid});
            check_value("out", 32'h0, out);
        end else begin
            if (reset_seen) begin
                check_value("out_valid", 32'h0, {31'h0, out_valid});
                check_value("out", 32'h0, out);
                reset_seen = 1'b0;
            end
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    fail_run("out_valid went high with no frame outstanding");
                end
                exp_res = exp_q.pop_front();
                due     = due_q.pop_front();
                check_value("out_valid cycle", due, ncyc);
                for (int f = 0; f < `CL_FILTERS; f++) begin
                    if (out[f] == 8'h80) begin
                        fail_run($sformatf("out[%0d] carries the code -128", f));
                    end
                    check_value($sformatf("out[%0d]", f), {24'h0, exp_res[f]}, {24'h0, out[f]});
                end
                n_out++;
            end else if (due_q.size() != 0 && due_q[0] <= ncyc) begin
                fail_run($sformatf("out_valid did not rise for the frame due in cycle %0d",
                                   due_q[0]));
            end
            if (en) begin
                exp_q.push_back(model_layer(act_in));
                due_q.push_back(ncyc + LATENCY);
                n_en++;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        fail_run($sformatf("Timeout: the run did not finish within %0d ns", WATCHDOG_NS));
    end

    initial begin
        int  f;
        bit  pos;
        void'($urandom(32'h781b6c9b));
        ncyc      = 0;
        n_en      = 0;
        n_out     = 0;
        n_dropped = 0;
        rst_n  <= 1'b0;
        en     <= 1'b0;
        act_in <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        // Back-to-back frames
        for (int i = 0; i < N_B2B; i++) begin
            drive_cycle(1'b1, random_frame());
        end
        idle(DRAIN);
        check_drained("back-to-back");

        // En high about half the time
        for (int i = 0; i < N_GAP; i++) begin
            drive_cycle(logic'($urandom_range(1)), random_frame());
        end
        idle(DRAIN);
        check_drained("gap");

        // Overflow in both directions
        for (int i = 0; i < N_SAT; i++) begin
            f   = $urandom_range(`CL_FILTERS - 1);
            pos = $urandom_range(1);
            drive_cycle(1'b1, saturating_frame(f, pos));
        end
        idle(DRAIN);
        check_drained("saturation");

        // Reset with frames still in the pipeline
        for (int i = 0; i < N_FLIGHT; i++) begin
            drive_cycle(1'b1, random_frame());
        end
        apply_reset(RESET_CYCLES);
        idle(DRAIN);

        for (int i = 0; i < N_AFTER; i++) begin
            drive_cycle(logic'($urandom_range(1)), random_frame());
        end
        idle(DRAIN);

        check_value("out_valid pulse count", n_en - n_dropped, n_out);
        if (exp_q.size() != 0) begin
            fail_run($sformatf("%0d frames left unchecked at the end", exp_q.size()));
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

//--- conv_layer.f
+incdir+.
conv_types_pkg.sv
conv_weights_pkg.sv
conv_input_stage.sv
conv_channel_mac.sv
conv_filter_sum.sv
conv_requant.sv
conv_layer.sv
tb_conv_layer.sv

//--- Bender.yml
package:
  name: conv_layer

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - conv_types_pkg.sv
      - conv_weights_pkg.sv
      - conv_input_stage.sv
      - conv_channel_mac.sv
      - conv_filter_sum.sv
      - conv_requant.sv
      - conv_layer.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_conv_layer.sv
